// ==== common/ntt_settings.svh ====
`ifndef NTT_SETTINGS_SVH
`define NTT_SETTINGS_SVH

// Coefficient width and the ML-DSA prime q = 2^23 - 2^13 + 1
`define NTT_REG_SIZE 23
`define NTT_Q 23'd8380417

// Pipeline depths in clock cycles
`define NTT_MUL_LATENCY 4
`define NTT_BF_LATENCY 5
`define NTT_NET_LATENCY 10

// Wishbone data width and word address width
`define NTT_WB_DW 32
`define NTT_WB_AW 5

`endif

// ==== common/ntt_arith_pkg.sv ====
`include "ntt_settings.svh"

package ntt_arith_pkg;

    // Operation of the butterfly network
    // Idle sits at zero so that a cleared CTRL register selects nothing
    typedef enum logic [2:0] {
        idle = 3'd0,
        ct   = 3'd1,
        gs   = 3'd2,
        pwm  = 3'd3,
        pwa  = 3'd4,
        pws  = 3'd5
    } mode_t;

    // One coefficient modulo q
    typedef logic [`NTT_REG_SIZE-1:0] coef_t;

    // Operand set of one radix-4 NTT slice
    typedef struct packed {
        coef_t u00;
        coef_t v00;
        coef_t w00;
        coef_t u01;
        coef_t v01;
        coef_t w01;
        coef_t w10;
        coef_t w11;
    } bf_uvw_t;

    // One pointwise lane with its three operands
    typedef struct packed {
        coef_t u;
        coef_t v;
        coef_t w;
    } pw_lane_t;

    // Four pointwise lanes in one operand set
    typedef struct packed {
        pw_lane_t [3:0] lane;
    } pw_uvw_t;

    // Four results shared by NTT and pointwise modes
    typedef struct packed {
        coef_t res3;
        coef_t res2;
        coef_t res1;
        coef_t res0;
    } bf_res_t;

endpackage

// ==== common/ntt_bus_pkg.sv ====
`include "ntt_settings.svh"

package ntt_bus_pkg;

    // Wishbone classic master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`NTT_WB_AW-1:0] adr;
        logic [`NTT_WB_DW-1:0] dat;
    } wb_req_t;

    // Wishbone classic slave to master
    typedef struct packed {
        logic                  ack;
        logic [`NTT_WB_DW-1:0] dat;
    } wb_rsp_t;

    // Word addresses of the register map
    typedef enum logic [`NTT_WB_AW-1:0] {
        CTRL   = 5'd0,
        STATUS = 5'd1,
        U0 = 5'd4,  U1 = 5'd5,  U2 = 5'd6,  U3 = 5'd7,
        V0 = 5'd8,  V1 = 5'd9,  V2 = 5'd10, V3 = 5'd11,
        W0 = 5'd12, W1 = 5'd13, W2 = 5'd14, W3 = 5'd15,
        RES0 = 5'd16, RES1 = 5'd17, RES2 = 5'd18, RES3 = 5'd19
    } reg_addr_t;

endpackage

// ==== butterfly/ntt_mod_mult.sv ====
`timescale 1ns/1ps
`include "ntt_settings.svh"

// Pipelined multiplier modulo q = 2^23 - 2^13 + 1
// Since 2^23 is congruent to 2^13 - 1 the high bits fold back with a shift and a subtract
module ntt_mod_mult (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  ntt_arith_pkg::coef_t a_i,
    input  ntt_arith_pkg::coef_t b_i,
    output ntt_arith_pkg::coef_t p_o
);
    localparam int W   = `NTT_REG_SIZE;
    localparam int PW  = 2 * W;
    localparam int F1W = W + 14;
    localparam int MW  = W + 5;
    localparam int FW  = W + 1;
    localparam logic [W:0] Q = {1'b0, `NTT_Q};

    logic [PW-1:0]  prod_q;
    logic [F1W-1:0] fold1, fold1_q;
    logic [MW-1:0]  mid;
    logic [FW-1:0]  fold2, fold2_q;
    logic [W-1:0]   p_q;

    always_comb begin
        // First fold takes the 46-bit product below 2^37
        fold1 = {1'b0, prod_q[PW-1:W], 13'b0} - F1W'(prod_q[PW-1:W])
                + F1W'(prod_q[W-1:0]);
        // Second fold leaves a 5-bit high part which folds once more in the same stage
        mid = {1'b0, fold1_q[F1W-1:W], 13'b0} - MW'(fold1_q[F1W-1:W])
              + MW'(fold1_q[W-1:0]);
        fold2 = FW'({mid[MW-1:W], 13'b0}) - FW'(mid[MW-1:W]) + FW'(mid[W-1:0]);
    end

    // ==================================================================
    // Four pipeline stages
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
            p_q     <= '0;
        end else if (zeroize_i) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
            p_q     <= '0;
        end else begin
            prod_q  <= PW'(a_i) * PW'(b_i);
            fold1_q <= fold1;
            fold2_q <= fold2;
            // The folded value is below 2q so one subtraction is enough
            p_q     <= (fold2_q >= Q) ? W'(fold2_q - Q) : fold2_q[W-1:0];
        end
    end

    assign p_o = p_q;

    // Whatever entered the pipeline the product leaves fully reduced
    assert property (@(posedge clk) disable iff (!reset_n) {1'b0, p_o} < Q);

endmodule

// ==== butterfly/ntt_butterfly.sv ====
`timescale 1ns/1ps
`include "ntt_settings.svh"

// One butterfly unit for ct, gs and the three pointwise operations
// All products go through the single modular multiplier
module ntt_butterfly (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 accumulate_i,
    input  ntt_arith_pkg::mode_t mode_i,
    input  ntt_arith_pkg::coef_t u_i,
    input  ntt_arith_pkg::coef_t v_i,
    input  ntt_arith_pkg::coef_t w_i,
    output ntt_arith_pkg::coef_t u_o,
    output ntt_arith_pkg::coef_t v_o,
    output ntt_arith_pkg::coef_t pw_o
);
    import ntt_arith_pkg::*;

    localparam int ML = `NTT_MUL_LATENCY;
    localparam logic [`NTT_REG_SIZE:0] Q = {1'b0, `NTT_Q};

    // Sum of two reduced values stays below 2q
    function automatic coef_t add_mod(coef_t a, coef_t b);
        logic [`NTT_REG_SIZE:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= Q) ? coef_t'(s - Q) : coef_t'(s);
    endfunction

    // Adding q first keeps the difference positive
    function automatic coef_t sub_mod(coef_t a, coef_t b);
        logic [`NTT_REG_SIZE:0] s;
        s = (a >= b) ? {1'b0, a} - {1'b0, b} : {1'b0, a} + Q - {1'b0, b};
        return coef_t'(s);
    endfunction

    coef_t          sum_q, dif_q;
    coef_t [ML-1:0] u_dly, w_dly;
    coef_t          mul_a, mul_b, prod;
    coef_t          u_q, v_q;

    // Multiplier operands
    // gs multiplies the registered difference with w one cycle late
    always_comb begin
        case (mode_i)
            gs: begin
                mul_a = dif_q;
                mul_b = w_dly[0];
            end
            pwm: begin
                mul_a = u_i;
                mul_b = v_i;
            end
            default: begin
                mul_a = v_i;
                mul_b = w_i;
            end
        endcase
    end

    ntt_mod_mult mult0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (prod)
    );

    // ==================================================================
    // Add and subtract stages with the delay lines
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q <= '0;
            dif_q <= '0;
            u_dly <= '0;
            w_dly <= '0;
            u_q   <= '0;
            v_q   <= '0;
        end else if (zeroize_i) begin
            sum_q <= '0;
            dif_q <= '0;
            u_dly <= '0;
            w_dly <= '0;
            u_q   <= '0;
            v_q   <= '0;
        end else begin
            // First stage serves gs as well as pwa and pws
            sum_q <= add_mod(u_i, v_i);
            dif_q <= sub_mod(u_i, v_i);
            // In ct the line carries u and in gs it picks up the sum one cycle in
            u_dly[0] <= u_i;
            u_dly[1] <= (mode_i == gs) ? sum_q : u_dly[0];
            for (int i = 2; i < ML; i++) begin
                u_dly[i] <= u_dly[i-1];
            end
            w_dly <= {w_dly[ML-2:0], w_i};
            // Output stage meets the product four cycles after the operands
            case (mode_i)
                ct:      u_q <= add_mod(u_dly[ML-1], prod);
                pwm:     u_q <= add_mod(prod, w_dly[ML-1]);
                default: u_q <= u_dly[ML-1];
            endcase
            v_q <= sub_mod(u_dly[ML-1], prod);
        end
    end

    assign u_o = u_q;
    // The gs product already arrives in the fifth cycle
    assign v_o = (mode_i == gs) ? prod : v_q;

    always_comb begin
        case (mode_i)
            pwm:     pw_o = accumulate_i ? u_q : prod;
            pwa:     pw_o = sum_q;
            pws:     pw_o = dif_q;
            default: pw_o = '0;
        endcase
    end

endmodule

// ==== butterfly/ntt_butterfly2x2.sv ====
`timescale 1ns/1ps
`include "ntt_settings.svh"

// Two stages of two butterflies each for one radix-4 slice
// Pointwise modes run the four units as independent lanes
module ntt_butterfly2x2 (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   enable_i,
    input  logic                   accumulate_i,
    input  ntt_arith_pkg::mode_t   mode_i,
    input  ntt_arith_pkg::bf_uvw_t uvw_i,
    input  ntt_arith_pkg::pw_uvw_t pw_uvw_i,
    output ntt_arith_pkg::bf_res_t res_o,
    output logic                   ready_o
);
    import ntt_arith_pkg::*;

    localparam int S1 = `NTT_BF_LATENCY;
    localparam int NL = `NTT_NET_LATENCY;
    localparam int ML = `NTT_MUL_LATENCY;

    // Unit index 0 is butterfly 00, then 01, 10 and 11
    coef_t [3:0]    bf_u, bf_v, bf_w;
    coef_t [3:0]    bf_uo, bf_vo, bf_pw;
    coef_t [S1-1:0] w10_dly, w11_dly;
    logic           pw_mode;
    logic [NL-1:0]  ready_sr, ready_nxt;
    int             depth;

    assign pw_mode = mode_i inside {pwm, pwa, pws};

    // Stage-two twiddles wait for the stage-one outputs
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly <= '0;
            w11_dly <= '0;
        end else if (zeroize_i) begin
            w10_dly <= '0;
            w11_dly <= '0;
        end else begin
            w10_dly <= {w10_dly[S1-2:0], uvw_i.w10};
            w11_dly <= {w11_dly[S1-2:0], uvw_i.w11};
        end
    end

    // ==================================================================
    // Operand steering
    // ==================================================================
    always_comb begin
        if (pw_mode) begin
            for (int k = 0; k < 4; k++) begin
                bf_u[k] = pw_uvw_i.lane[k].u;
                bf_v[k] = pw_uvw_i.lane[k].v;
                bf_w[k] = pw_uvw_i.lane[k].w;
            end
        end else begin
            bf_u[0] = uvw_i.u00;
            bf_v[0] = uvw_i.v00;
            bf_w[0] = uvw_i.w00;
            bf_u[1] = uvw_i.u01;
            bf_v[1] = uvw_i.v01;
            bf_w[1] = uvw_i.w01;
            // Butterfly 10 combines the u outputs and butterfly 11 the v outputs
            bf_u[2] = bf_uo[0];
            bf_v[2] = bf_uo[1];
            bf_w[2] = w10_dly[S1-1];
            bf_u[3] = bf_vo[0];
            bf_v[3] = bf_vo[1];
            bf_w[3] = w11_dly[S1-1];
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_bf
        ntt_butterfly bf (
            .clk          (clk),
            .reset_n      (reset_n),
            .zeroize_i    (zeroize_i),
            .accumulate_i (accumulate_i),
            .mode_i       (mode_i),
            .u_i          (bf_u[g]),
            .v_i          (bf_v[g]),
            .w_i          (bf_w[g]),
            .u_o          (bf_uo[g]),
            .v_o          (bf_vo[g]),
            .pw_o         (bf_pw[g])
        );
    end

    always_comb begin
        if (pw_mode) begin
            res_o.res0 = bf_pw[0];
            res_o.res1 = bf_pw[1];
            res_o.res2 = bf_pw[2];
            res_o.res3 = bf_pw[3];
        end else begin
            res_o.res0 = bf_uo[2];
            res_o.res1 = bf_vo[2];
            res_o.res2 = bf_uo[3];
            res_o.res3 = bf_vo[3];
        end
    end

    // ==================================================================
    // Ready tracking
    // ==================================================================
    // Enable enters the shift register at the depth of the current mode
    always_comb begin
        case (mode_i)
            ct, gs:   depth = NL;
            pwm:      depth = accumulate_i ? ML + 1 : ML;
            pwa, pws: depth = 1;
            default:  depth = 0;
        endcase
        ready_nxt = ready_sr >> 1;
        if (depth != 0) begin
            ready_nxt[depth-1] = ready_nxt[depth-1] | enable_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= '0;
        end else if (zeroize_i) begin
            ready_sr <= '0;
        end else begin
            ready_sr <= ready_nxt;
        end
    end

    assign ready_o = ready_sr[0];

    // The front end samples ready every cycle so it must stay known
    assert property (@(posedge clk) disable iff (!reset_n) !$isunknown(ready_o));

endmodule

// ==== src/ntt_wb_regs.sv ====
`timescale 1ns/1ps
`include "ntt_settings.svh"

// Wishbone classic register front end of the butterfly network
module ntt_wb_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  ntt_bus_pkg::wb_req_t   wb_req_i,
    output ntt_bus_pkg::wb_rsp_t   wb_rsp_o,
    output ntt_arith_pkg::mode_t   mode_o,
    output logic                   accumulate_o,
    output logic                   enable_o,
    output logic                   zeroize_o,
    output ntt_arith_pkg::bf_uvw_t uvw_o,
    output ntt_arith_pkg::pw_uvw_t pw_uvw_o,
    input  ntt_arith_pkg::bf_res_t res_i,
    input  logic                   ready_i
);
    import ntt_arith_pkg::*;
    import ntt_bus_pkg::*;

    localparam int DW = `NTT_WB_DW;
    localparam int W  = `NTT_REG_SIZE;

    logic          req, wr, wr_ctrl;
    reg_addr_t     addr;
    logic [1:0]    idx;
    logic [DW-1:0] rd_data, dat_q;
    logic          ack_q, start_q, done_q, busy_q, acc_q;
    mode_t         mode_q;
    coef_t [3:0]   u_q, v_q, w_q, res_q;

    // A request is served once and the cycle of its ack is skipped
    assign req     = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr      = req && wb_req_i.we;
    assign addr    = reg_addr_t'(wb_req_i.adr);
    assign idx     = wb_req_i.adr[1:0];
    assign wr_ctrl = wr && (addr == CTRL);

    always_comb begin
        case (addr) inside
            CTRL:          rd_data = DW'({acc_q, mode_q});
            STATUS:        rd_data = DW'({busy_q, done_q});
            [U0:U3]:       rd_data = DW'(u_q[idx]);
            [V0:V3]:       rd_data = DW'(v_q[idx]);
            [W0:W3]:       rd_data = DW'(w_q[idx]);
            [RES0:RES3]:   rd_data = DW'(res_q[idx]);
            default:       rd_data = '0;
        endcase
    end

    // ==================================================================
    // Bus handshake and control pulses
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q     <= 1'b0;
            dat_q     <= '0;
            start_q   <= 1'b0;
            enable_o  <= 1'b0;
            zeroize_o <= 1'b0;
        end else begin
            ack_q     <= req;
            dat_q     <= req ? rd_data : '0;
            // Start reaches the network one cycle after the ack
            start_q   <= wr_ctrl && wb_req_i.dat[4];
            enable_o  <= start_q;
            zeroize_o <= wr_ctrl && wb_req_i.dat[5];
        end
    end

    // ==================================================================
    // Register storage and status
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= idle;
            acc_q  <= 1'b0;
            u_q    <= '0;
            v_q    <= '0;
            w_q    <= '0;
            res_q  <= '0;
            done_q <= 1'b0;
            busy_q <= 1'b0;
        end else if (zeroize_o) begin
            // Zeroize clears data and status but keeps the mode setting
            u_q    <= '0;
            v_q    <= '0;
            w_q    <= '0;
            res_q  <= '0;
            done_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            if (wr) begin
                case (addr) inside
                    CTRL: begin
                        mode_q <= mode_t'(wb_req_i.dat[2:0]);
                        acc_q  <= wb_req_i.dat[3];
                    end
                    [U0:U3]: u_q[idx] <= wb_req_i.dat[W-1:0];
                    [V0:V3]: v_q[idx] <= wb_req_i.dat[W-1:0];
                    [W0:W3]: w_q[idx] <= wb_req_i.dat[W-1:0];
                    default: ;
                endcase
            end
            if (start_q) begin
                done_q <= 1'b0;
            end
            if (enable_o) begin
                busy_q <= 1'b1;
            end
            if (ready_i) begin
                res_q  <= {res_i.res3, res_i.res2, res_i.res1, res_i.res0};
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;
    assign mode_o       = mode_q;
    assign accumulate_o = acc_q;

    // NTT operands take lanes 0 and 1 for stage one and W2 and W3 as stage-two twiddles
    always_comb begin
        uvw_o.u00 = u_q[0];
        uvw_o.v00 = v_q[0];
        uvw_o.w00 = w_q[0];
        uvw_o.u01 = u_q[1];
        uvw_o.v01 = v_q[1];
        uvw_o.w01 = w_q[1];
        uvw_o.w10 = w_q[2];
        uvw_o.w11 = w_q[3];
        for (int k = 0; k < 4; k++) begin
            pw_uvw_o.lane[k].u = u_q[k];
            pw_uvw_o.lane[k].v = v_q[k];
            pw_uvw_o.lane[k].w = w_q[k];
        end
    end

    // Every ack answers a request seen on the previous edge
    assert property (@(posedge clk) disable iff (!reset_n)
        wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

// ==== src/ntt_bf_top.sv ====
`timescale 1ns/1ps

// Register front end driving the 2x2 butterfly network
module ntt_bf_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  ntt_bus_pkg::wb_req_t wb_req_i,
    output ntt_bus_pkg::wb_rsp_t wb_rsp_o
);
    import ntt_arith_pkg::*;

    mode_t   mode;
    logic    accumulate, enable, zeroize, ready;
    bf_uvw_t uvw;
    pw_uvw_t pw_uvw;
    bf_res_t res;

    ntt_wb_regs regs0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .enable_o     (enable),
        .zeroize_o    (zeroize),
        .uvw_o        (uvw),
        .pw_uvw_o     (pw_uvw),
        .res_i        (res),
        .ready_i      (ready)
    );

    ntt_butterfly2x2 net0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .enable_i     (enable),
        .accumulate_i (accumulate),
        .mode_i       (mode),
        .uvw_i        (uvw),
        .pw_uvw_i     (pw_uvw),
        .res_o        (res),
        .ready_o      (ready)
    );

endmodule

// ==== dv/ntt_bf_tb.sv ====
`timescale 1ns/1ps
`include "ntt_settings.svh"

// Directed testbench for the butterfly network behind its Wishbone front end
module ntt_bf_tb;
    import ntt_arith_pkg::*;
    import ntt_bus_pkg::*;

    localparam longint unsigned Q = 64'(`NTT_Q);

    logic        clk;
    logic        reset_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          mismatches;
    int          timeouts;
    logic [31:0] op_u [4];
    logic [31:0] op_v [4];
    logic [31:0] op_w [4];
    logic [31:0] got [4];
    logic [31:0] exp_r [4];
    logic [31:0] rd;

    ntt_bf_top dut0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    always #20 clk = ~clk;

    // ==================================================================
    // Reference arithmetic modulo q
    // ==================================================================
    function automatic longint unsigned add_q(longint unsigned a, longint unsigned b);
        return (a + b) % Q;
    endfunction

    function automatic longint unsigned sub_q(longint unsigned a, longint unsigned b);
        return (a + Q - b) % Q;
    endfunction

    function automatic longint unsigned mul_q(longint unsigned a, longint unsigned b);
        return (a * b) % Q;
    endfunction

    // One butterfly that is Cooley-Tukey when is_ct is set and Gentleman-Sande otherwise
    task automatic bf_ref(input bit is_ct, input longint unsigned u, v, w,
                          output longint unsigned uo, vo);
        if (is_ct) begin
            uo = add_q(u, mul_q(v, w));
            vo = sub_q(u, mul_q(v, w));
        end else begin
            uo = add_q(u, v);
            vo = mul_q(sub_q(u, v), w);
        end
    endtask

    // Stage two pairs the u outputs under W2 and the v outputs under W3
    task automatic model_ntt(input bit is_ct);
        longint unsigned a0, b0, a1, b1, r0, r1, r2, r3;
        bf_ref(is_ct, op_u[0], op_v[0], op_w[0], a0, b0);
        bf_ref(is_ct, op_u[1], op_v[1], op_w[1], a1, b1);
        bf_ref(is_ct, a0, a1, op_w[2], r0, r1);
        bf_ref(is_ct, b0, b1, op_w[3], r2, r3);
        exp_r[0] = 32'(r0);
        exp_r[1] = 32'(r1);
        exp_r[2] = 32'(r2);
        exp_r[3] = 32'(r3);
    endtask

    task automatic model_pw(input mode_t mode, input bit acc);
        for (int k = 0; k < 4; k++) begin
            case (mode)
                pwm:     exp_r[k] = 32'(acc ? add_q(mul_q(op_u[k], op_v[k]), op_w[k])
                                            : mul_q(op_u[k], op_v[k]));
                pwa:     exp_r[k] = 32'(add_q(op_u[k], op_v[k]));
                default: exp_r[k] = 32'(sub_q(op_u[k], op_v[k]));
            endcase
        end
    endtask

    // ==================================================================
    // Bus access and checks
    // ==================================================================
    // Request goes out 2 ns after an edge and is held until ack shows up
    task automatic bus_cycle(input bit we, input logic [4:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!wb_rsp.ack && n < 16);
        assert (wb_rsp.ack) else begin
            timeouts++;
            $display("No ack from the slave for address %0d within 16 cycles", adr);
        end
        rdat = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic check_val(input string test, input logic [31:0] expv, act);
        assert (act === expv) else begin
            mismatches++;
            $display("mismatch %s expected 0x%06h actual 0x%06h", test, expv, act);
        end
    endtask

    task automatic check_res(input string test);
        for (int k = 0; k < 4; k++) begin
            check_val(test, exp_r[k], got[k]);
        end
    endtask

    task automatic fill_random();
        for (int k = 0; k < 4; k++) begin
            op_u[k] = 32'($urandom % Q);
            op_v[k] = 32'($urandom % Q);
            op_w[k] = 32'($urandom % Q);
        end
    endtask

    // Loads all operands, starts one operation and collects the four results
    task automatic run_op(input mode_t mode, input bit acc, input string test);
        int n;
        bit done;
        bit busy_seen;
        for (int k = 0; k < 4; k++) begin
            wb_write(5'(U0 + k), op_u[k]);
            wb_write(5'(V0 + k), op_v[k]);
            wb_write(5'(W0 + k), op_w[k]);
        end
        wb_write(CTRL, 32'h10 | {28'b0, acc, mode});
        done = 1'b0;
        busy_seen = 1'b0;
        n = 0;
        while (!done && n < 64) begin
            wb_read(STATUS, rd);
            done = rd[0];
            busy_seen = busy_seen | rd[1];
            n++;
        end
        assert (done) else begin
            timeouts++;
            $display("%s never set done in STATUS within 64 polls", test);
        end
        // Busy drops on the same edge that raises done
        if (done) begin
            check_val(test, 32'h1, rd);
        end
        // A ten-cycle slice outlasts the two-cycle polling period so busy must show up
        if (mode inside {ct, gs}) begin
            check_val(test, 32'h1, 32'(busy_seen));
        end
        for (int k = 0; k < 4; k++) begin
            wb_read(5'(RES0 + k), got[k]);
        end
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================
    task automatic test_reset();
        for (int a = 0; a < 20; a++) begin
            wb_read(5'(a), rd);
            check_val("reset", 32'h0, rd);
        end
        wb_write(V2, 32'h5A5A5A);
        wb_read(V2, rd);
        check_val("reset", 32'h5A5A5A, rd);
    endtask

    task automatic test_ct();
        repeat (4) begin
            fill_random();
            model_ntt(1'b1);
            run_op(ct, 1'b0, "ct");
            check_res("ct");
        end
    endtask

    task automatic test_gs();
        repeat (3) begin
            fill_random();
            model_ntt(1'b0);
            run_op(gs, 1'b0, "gs");
            check_res("gs");
        end
        // Edge values with u at zero and everything else at q-1
        for (int k = 0; k < 4; k++) begin
            op_u[k] = (k < 2) ? 32'h0 : 32'(Q - 1);
            op_v[k] = 32'(Q - 1);
            op_w[k] = 32'(Q - 1);
        end
        model_ntt(1'b0);
        run_op(gs, 1'b0, "gs_edge");
        check_res("gs_edge");
    endtask

    task automatic test_pwm();
        string name;
        for (int acc = 0; acc < 2; acc++) begin
            name = "pwm";
            if (acc != 0) begin
                name = "pwm_acc";
            end
            fill_random();
            model_pw(pwm, acc[0]);
            run_op(pwm, acc[0], name);
            check_res(name);
            // CTRL keeps the mode and accumulate bits of the last write
            wb_read(CTRL, rd);
            check_val(name, {28'b0, acc[0], pwm}, rd);
        end
    endtask

    task automatic test_pwa_pws();
        fill_random();
        model_pw(pwa, 1'b0);
        run_op(pwa, 1'b0, "pwa");
        check_res("pwa");
        model_pw(pws, 1'b0);
        run_op(pws, 1'b0, "pws");
        check_res("pws");
        // u below v makes the subtraction wrap around q
        for (int k = 0; k < 4; k++) begin
            op_u[k] = 32'(k * 3);
            op_v[k] = 32'(Q - 1 - k);
        end
        model_pw(pws, 1'b0);
        run_op(pws, 1'b0, "pws_wrap");
        check_res("pws_wrap");
        model_pw(pwa, 1'b0);
        run_op(pwa, 1'b0, "pwa_wrap");
        check_res("pwa_wrap");
    endtask

    task automatic test_zeroize();
        fill_random();
        model_ntt(1'b1);
        run_op(ct, 1'b0, "zeroize_pre");
        check_res("zeroize_pre");
        wb_write(CTRL, 32'h20);
        wb_read(STATUS, rd);
        check_val("zeroize", 32'h0, rd);
        for (int k = 0; k < 4; k++) begin
            wb_read(5'(RES0 + k), rd);
            check_val("zeroize", 32'h0, rd);
        end
        // The cleared pipeline must still compute a fresh slice
        fill_random();
        model_ntt(1'b1);
        run_op(ct, 1'b0, "zeroize_post");
        check_res("zeroize_post");
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        wb_req     = '0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(58));
        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_reset();
        test_ct();
        test_gs();
        test_pwm();
        test_pwa_pws();
        test_zeroize();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/ntt_arith_pkg.sv
common/ntt_bus_pkg.sv
butterfly/ntt_mod_mult.sv
butterfly/ntt_butterfly.sv
butterfly/ntt_butterfly2x2.sv
src/ntt_wb_regs.sv
src/ntt_bf_top.sv
dv/ntt_bf_tb.sv

// ==== Makefile ====
TOP = ntt_bf_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -sv -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -sv -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
